//--- source/core_config_pkg.sv
package core_config_pkg;

    // Vector width in 32-bit lanes
    localparam int VECTOR_LANES = 4;

    // Hardware threads sharing the fetch stage
    localparam int THREADS = 2;
    localparam int NUM_REGS = 32;

    // Queue entries, equal to the upstream credit count
    localparam int QUEUE_DEPTH = 4;

    // Free slots on the execute side after reset
    localparam int EXEC_CREDITS = 4;

endpackage

//--- source/core_types_pkg.sv
package core_types_pkg;

    import core_config_pkg::*;

    typedef logic [31:0] scalar_t;

    // Lane 0 is the lowest word
    typedef scalar_t [VECTOR_LANES - 1:0] vector_t;
    typedef logic [VECTOR_LANES - 1:0] lane_mask_t;

    typedef logic [$clog2(THREADS) - 1:0] thread_idx_t;
    typedef logic [$clog2(NUM_REGS) - 1:0] register_idx_t;

    typedef enum logic {
        OP1_SRC_SCALAR1,
        OP1_SRC_VECTOR1
    } op1_src_t;

    typedef enum logic [1:0] {
        OP2_SRC_SCALAR2,
        OP2_SRC_VECTOR2,
        OP2_SRC_IMMEDIATE
    } op2_src_t;

    typedef enum logic [1:0] {
        MASK_SRC_ALL_ONES,
        MASK_SRC_SCALAR1,
        MASK_SRC_SCALAR2
    } mask_src_t;

    // Both views start with the same 6-bit header.
    // imm_form applies when op2_src is OP2_SRC_IMMEDIATE
    typedef union packed {
        struct packed {
            op1_src_t op1_src;
            op2_src_t op2_src;
            mask_src_t mask_src;
            logic store_is_vector;
            register_idx_t scalar_sel1;
            register_idx_t scalar_sel2;
            register_idx_t vector_sel1;
            register_idx_t vector_sel2;
            logic [5:0] padding;
        } reg_form;
        struct packed {
            op1_src_t op1_src;
            op2_src_t op2_src;
            mask_src_t mask_src;
            logic store_is_vector;
            register_idx_t scalar_sel1;
            register_idx_t vector_sel1;
            logic [15:0] immediate;
        } imm_form;
    } instr_word_u;

    // Holds 0 to EXEC_CREDITS
    typedef logic [$clog2(EXEC_CREDITS + 1) - 1:0] credit_count_t;

endpackage

//--- source/sram_2r1w.sv
`timescale 1ns/10ps

module sram_2r1w
    #(parameter DATA_WIDTH = 32,
    parameter SIZE = 64)
    (input                             clk,
    input                              read1_en,
    input [$clog2(SIZE) - 1:0]         read1_addr,
    output logic [DATA_WIDTH - 1:0]    read1_data,
    input                              read2_en,
    input [$clog2(SIZE) - 1:0]         read2_addr,
    output logic [DATA_WIDTH - 1:0]    read2_data,
    input                              write_en,
    input [$clog2(SIZE) - 1:0]         write_addr,
    input [DATA_WIDTH - 1:0]           write_data);

    logic [DATA_WIDTH - 1:0] data[SIZE];

    always_ff @(posedge clk)
    begin
        if (write_en)
            data[write_addr] <= write_data;

        // Read ports hold their last value while disabled
        if (read1_en)
            read1_data <= data[read1_addr];

        if (read2_en)
            read2_data <= data[read2_addr];
    end
endmodule

//--- source/instruction_queue.sv
`timescale 1ns/10ps

module instruction_queue
    import core_config_pkg::*;
    import core_types_pkg::*;
    (input                  clk,
    input                   reset,
    input                   in_valid,
    input instr_word_u      in_instr,
    input thread_idx_t      in_thread,
    input                   pop,
    output logic            empty,
    output instr_word_u     head_instr,
    output thread_idx_t     head_thread,
    output logic            in_credit);

    instr_word_u instr_entries[QUEUE_DEPTH];
    thread_idx_t thread_entries[QUEUE_DEPTH];
    logic [$clog2(QUEUE_DEPTH) - 1:0] write_ptr;
    logic [$clog2(QUEUE_DEPTH) - 1:0] read_ptr;
    logic [$clog2(QUEUE_DEPTH + 1) - 1:0] count;
    logic do_pop;

    assign empty = count == 0;
    assign do_pop = pop && !empty;
    assign head_instr = instr_entries[read_ptr];
    assign head_thread = thread_entries[read_ptr];

    // Upstream only pushes while it holds a credit, so no full check here
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            instr_entries[write_ptr] <= in_instr;
            thread_entries[write_ptr] <= in_thread;
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            write_ptr <= '0;
            read_ptr <= '0;
            count <= '0;
            in_credit <= 1'b0;
        end
        else
        begin
            if (in_valid)
                write_ptr <= write_ptr + 1'b1;

            if (do_pop)
                read_ptr <= read_ptr + 1'b1;

            if (in_valid && !do_pop)
                count <= count + 1'b1;
            else if (!in_valid && do_pop)
                count <= count - 1'b1;

            // Each freed entry goes back upstream as one credit
            in_credit <= do_pop;
        end
    end
endmodule

//--- source/credit_counter.sv
`timescale 1ns/10ps

module credit_counter
    import core_config_pkg::*;
    import core_types_pkg::*;
    (input          clk,
    input           reset,
    input           issue,
    input           credit_return,
    input [1:0]     squash_count,
    output logic    credit_avail);

    credit_count_t credit_count;
    logic [$bits(credit_count_t):0] returned;
    logic [$bits(credit_count_t):0] next_count;

    assign credit_avail = credit_count != 0;

    always_comb
    begin
        // One extra bit so a return plus two squashes cannot wrap
        returned = {1'b0, credit_count} + {3'b000, credit_return} + {2'b00, squash_count};
        if (issue && returned != 0)
            next_count = returned - 1'b1;
        else
            next_count = returned;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            credit_count <= credit_count_t'(EXEC_CREDITS);
        else if (next_count > EXEC_CREDITS)
            credit_count <= credit_count_t'(EXEC_CREDITS);
        else
            credit_count <= next_count[$bits(credit_count_t) - 1:0];
    end
endmodule

//--- source/issue_control.sv
`timescale 1ns/10ps

module issue_control
    (input          clk,
    input           reset,
    input           queue_empty,
    input           credit_avail,
    output logic    issue);

    enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_CREDIT
    } state, next_state;

    // Pop and issue in the same cycle the head is valid and a slot is free
    assign issue = !queue_empty && credit_avail;

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (!queue_empty)
                    next_state = credit_avail ? ISSUE : WAIT_CREDIT;
            end

            ISSUE:
            begin
                if (queue_empty)
                    next_state = IDLE;
                else if (!credit_avail)
                    next_state = WAIT_CREDIT;
            end

            // Stall episode ends once execute returns a slot
            WAIT_CREDIT:
            begin
                if (queue_empty)
                    next_state = IDLE;
                else if (credit_avail)
                    next_state = ISSUE;
            end

            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= next_state;
    end
endmodule

//--- source/operand_fetch_stage.sv
`timescale 1ns/10ps

module operand_fetch_stage
    import core_config_pkg::*;
    import core_types_pkg::*;
    (input                  clk,
    input                   reset,
    input                   issue,
    input instr_word_u      instr,
    input thread_idx_t      thread,
    input                   wb_en,
    input thread_idx_t      wb_thread,
    input register_idx_t    wb_reg,
    input                   wb_is_vector,
    input vector_t          wb_value,
    input lane_mask_t       wb_mask,
    input                   rollback_en,
    input thread_idx_t      rollback_thread,
    output logic            out_valid,
    output thread_idx_t     out_thread,
    output vector_t         out_operand1,
    output vector_t         out_operand2,
    output lane_mask_t      out_mask,
    output vector_t         out_store_value,
    output logic [1:0]      squash_count);

    logic issue_is_imm;
    register_idx_t vector_sel1;
    logic issue_squash;
    logic cyc1_squash;
    logic cyc1_valid;
    instr_word_u cyc1_instr;
    thread_idx_t cyc1_thread;
    logic cyc1_is_imm;
    scalar_t immediate_value;
    scalar_t scalar_val1;
    scalar_t scalar_val2;
    vector_t vector_val1;
    vector_t vector_val2;

    // vector_sel1 sits in a different field in the immediate view
    assign issue_is_imm = instr.reg_form.op2_src == OP2_SRC_IMMEDIATE;
    assign vector_sel1 = issue_is_imm ? instr.imm_form.vector_sel1
        : instr.reg_form.vector_sel1;

    // Cycle 1: register file reads, addressed by {thread, register}
    sram_2r1w #(
        .DATA_WIDTH($bits(scalar_t)),
        .SIZE(THREADS * NUM_REGS)
    ) scalar_regs(
        .clk,
        .read1_en(issue),
        .read1_addr({thread, instr.reg_form.scalar_sel1}),
        .read1_data(scalar_val1),
        .read2_en(issue && !issue_is_imm),
        .read2_addr({thread, instr.reg_form.scalar_sel2}),
        .read2_data(scalar_val2),
        .write_en(wb_en && !wb_is_vector),
        .write_addr({wb_thread, wb_reg}),
        .write_data(wb_value[0]));

    genvar lane;
    generate
        for (lane = 0; lane < VECTOR_LANES; lane++)
        begin : vector_lane_gen
            sram_2r1w #(
                .DATA_WIDTH($bits(scalar_t)),
                .SIZE(THREADS * NUM_REGS)
            ) vector_regs(
                .clk,
                .read1_en(issue),
                .read1_addr({thread, vector_sel1}),
                .read1_data(vector_val1[lane]),
                .read2_en(issue && !issue_is_imm),
                .read2_addr({thread, instr.reg_form.vector_sel2}),
                .read2_data(vector_val2[lane]),
                .write_en(wb_en && wb_is_vector && wb_mask[lane]),
                .write_addr({wb_thread, wb_reg}),
                .write_data(wb_value[lane]));
        end
    endgenerate

    // Rollback kills the entering and the cycle 1 instruction of that thread
    assign issue_squash = issue && rollback_en && rollback_thread == thread;
    assign cyc1_squash = cyc1_valid && rollback_en && rollback_thread == cyc1_thread;
    assign squash_count = {1'b0, issue_squash} + {1'b0, cyc1_squash};

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            cyc1_valid <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            cyc1_valid <= issue && !issue_squash;
            out_valid <= cyc1_valid && !cyc1_squash;
        end
    end

    always_ff @(posedge clk)
    begin
        cyc1_instr <= instr;
        cyc1_thread <= thread;
    end

    // Cycle 2: steer register values onto the operand outputs
    assign cyc1_is_imm = cyc1_instr.reg_form.op2_src == OP2_SRC_IMMEDIATE;
    assign immediate_value = scalar_t'(signed'(cyc1_instr.imm_form.immediate));

    always_ff @(posedge clk)
    begin
        out_thread <= cyc1_thread;

        if (cyc1_instr.reg_form.op1_src == OP1_SRC_VECTOR1)
            out_operand1 <= vector_val1;
        else
            out_operand1 <= {VECTOR_LANES{scalar_val1}};

        case (cyc1_instr.reg_form.op2_src)
            OP2_SRC_SCALAR2: out_operand2 <= {VECTOR_LANES{scalar_val2}};
            OP2_SRC_VECTOR2: out_operand2 <= vector_val2;
            default:         out_operand2 <= {VECTOR_LANES{immediate_value}};
        endcase

        // No scalar 2 exists in the immediate view, so fall back to all ones
        case (cyc1_instr.reg_form.mask_src)
            MASK_SRC_SCALAR1:
                out_mask <= scalar_val1[VECTOR_LANES - 1:0];
            MASK_SRC_SCALAR2:
                out_mask <= cyc1_is_imm ? '1 : scalar_val2[VECTOR_LANES - 1:0];
            default:
                out_mask <= '1;
        endcase

        if (cyc1_instr.reg_form.store_is_vector)
            out_store_value <= vector_val2;
        else
            out_store_value <= {{(VECTOR_LANES - 1) * $bits(scalar_t){1'b0}}, scalar_val2};
    end
endmodule

//--- source/operand_fetch_unit.sv
`timescale 1ns/10ps

module operand_fetch_unit
    import core_types_pkg::*;
    (input                  clk,
    input                   reset,

    // Upstream scheduler
    input                   in_valid,
    input instr_word_u      in_instr,
    input thread_idx_t      in_thread,
    output logic            in_credit,

    // Writeback and rollback
    input                   wb_en,
    input thread_idx_t      wb_thread,
    input register_idx_t    wb_reg,
    input                   wb_is_vector,
    input vector_t          wb_value,
    input lane_mask_t       wb_mask,
    input                   rollback_en,
    input thread_idx_t      rollback_thread,

    // Execute side
    input                   exec_credit_return,
    output logic            out_valid,
    output thread_idx_t     out_thread,
    output vector_t         out_operand1,
    output vector_t         out_operand2,
    output lane_mask_t      out_mask,
    output vector_t         out_store_value);

    logic queue_empty;
    instr_word_u head_instr;
    thread_idx_t head_thread;
    logic issue;
    logic credit_avail;
    logic [1:0] squash_count;

    instruction_queue queue(
        .clk,
        .reset,
        .in_valid,
        .in_instr,
        .in_thread,
        .pop(issue),
        .empty(queue_empty),
        .head_instr,
        .head_thread,
        .in_credit);

    issue_control issue_fsm(
        .clk,
        .reset,
        .queue_empty,
        .credit_avail,
        .issue);

    // Squashed instructions hand their slot back on the same edge
    credit_counter credits(
        .clk,
        .reset,
        .issue,
        .credit_return(exec_credit_return),
        .squash_count,
        .credit_avail);

    operand_fetch_stage fetch(
        .clk,
        .reset,
        .issue,
        .instr(head_instr),
        .thread(head_thread),
        .wb_en,
        .wb_thread,
        .wb_reg,
        .wb_is_vector,
        .wb_value,
        .wb_mask,
        .rollback_en,
        .rollback_thread,
        .out_valid,
        .out_thread,
        .out_operand1,
        .out_operand2,
        .out_mask,
        .out_store_value,
        .squash_count);
endmodule

//--- tests/operand_fetch_asserts.sv
`timescale 1ns/10ps

module operand_fetch_asserts
    import core_config_pkg::*;
    import core_types_pkg::*;
    (input              clk,
    input               reset,
    input               issue,
    input               exec_credit_return,
    input               rollback_en,
    input thread_idx_t  rollback_thread,
    input thread_idx_t  head_thread,
    input               out_valid,
    input thread_idx_t  out_thread,
    input               in_credit,
    input [1:0]         state,
    input [2:0]         credit_count,
    input [3:0]         next_count,
    input [1:0]         squash_count);

    // Free slots before saturation, so a surplus return shows up here
    assert property (@(posedge clk) disable iff (reset) next_count <= EXEC_CREDITS)
        else $error("Credit count above limit");

    // State 2 is WAIT_CREDIT, a stall episode ends only after a slot comes back
    assert property (@(posedge clk) disable iff (reset)
        state == 2'd2 && issue |-> $past(exec_credit_return || squash_count != 0))
        else $error("Issue during a stall with no credit returned");

    // An issue reaches out_valid two cycles later unless its thread is rolled back
    assert property (@(posedge clk) disable iff (reset)
        $past(issue, 2) && !$past(rollback_en && rollback_thread == head_thread, 2)
            && !($past(rollback_en) && $past(rollback_thread) == $past(head_thread, 2))
        |-> out_valid && out_thread == $past(head_thread, 2))
        else $error("Issued instruction did not reach out_valid");

    assert property (@(posedge clk) disable iff (reset) out_valid |-> $past(issue, 2))
        else $error("out_valid with no issue two cycles earlier");

    assert property (@(posedge clk) $fell(reset) |-> !out_valid && !in_credit && !issue
        && credit_count == EXEC_CREDITS)
        else $error("Outputs not idle after reset");
endmodule

bind operand_fetch_unit operand_fetch_asserts checker_inst(
    .clk,
    .reset,
    .issue,
    .exec_credit_return,
    .rollback_en,
    .rollback_thread,
    .head_thread,
    .out_valid,
    .out_thread,
    .in_credit,
    .state(issue_fsm.state),
    .credit_count(credits.credit_count),
    .next_count(credits.next_count),
    .squash_count);

//--- tests/operand_fetch_tb.sv
`timescale 1ns/10ps

module operand_fetch_tb
    import core_config_pkg::*;
    import core_types_pkg::*;
    ();

    logic clk, reset, in_valid, in_credit, wb_en, wb_is_vector;
    logic rollback_en, exec_credit_return, out_valid;
    instr_word_u in_instr;
    thread_idx_t in_thread, wb_thread, rollback_thread, out_thread;
    register_idx_t wb_reg;
    vector_t wb_value, out_operand1, out_operand2, out_store_value;
    lane_mask_t wb_mask, out_mask;

    // Expected results in issue order
    int exp_thread[$];
    vector_t exp_op1[$], exp_op2[$], exp_store[$];
    lane_mask_t exp_mask[$];
    int due_q[$];
    int errors, checks, test_start_errors, test_start_checks, cycle_count;
    int up_credits, held_outputs, held_pulses;
    bit hold_credits, test_open, aborted;
    logic [15:0] lfsr_state;
    string test_name;

    operand_fetch_unit DUT(.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit)
            lfsr_state = lfsr_state ^ 16'hb400;
        return out_bit;
    endfunction

    // Return delay of 1 to 8 cycles from three LFSR bits
    function automatic int return_delay();
        int delay;
        delay = 0;
        for (int i = 0; i < 3; i++)
            delay = delay * 2 + int'(lfsr_step());
        return delay + 1;
    endfunction

    task automatic compare(string name, logic [127:0] got, logic [127:0] expected);
        checks++;
        if (got !== expected)
        begin
            $display("[FAIL] %s expected %h got %h", name, expected, got);
            errors++;
        end
    endtask

    // Output checker, upstream credit model and execute credit model
    always @(posedge clk)
    begin
        if (reset)
            up_credits = QUEUE_DEPTH;
        else
        begin
            cycle_count++;
            up_credits = up_credits - int'(in_valid) + int'(in_credit);
            if (hold_credits)
            begin
                held_outputs += int'(out_valid);
                held_pulses += int'(in_credit);
            end
            if (out_valid && exp_thread.size() == 0)
            begin
                $display("Output appeared with no instruction pending");
                errors++;
            end
            else if (out_valid)
            begin
                compare("out_thread", 128'(out_thread), 128'(exp_thread.pop_front()));
                compare("out_operand1", out_operand1, exp_op1.pop_front());
                compare("out_operand2", out_operand2, exp_op2.pop_front());
                compare("out_mask", 128'(out_mask), 128'(exp_mask.pop_front()));
                compare("out_store_value", out_store_value, exp_store.pop_front());
                due_q.push_back(cycle_count + return_delay());
            end
        end
        #2;
        exec_credit_return = 1'b0;
        if (!hold_credits && due_q.size() > 0 && due_q[0] <= cycle_count)
        begin
            exec_credit_return = 1'b1;
            void'(due_q.pop_front());
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_thread.size() > 0 && !aborted)
        begin
            next_cycle();
            waited++;
            if (waited > 500)
            begin
                $display("Timeout waiting for outputs of test %s", test_name);
                errors++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic close_test();
        if (test_open)
        begin
            drain_outputs();
            $display("Test %s finished: %0d checks, %0d errors", test_name,
                checks - test_start_checks, errors - test_start_errors);
        end
        test_start_checks = checks;
        test_start_errors = errors;
    endtask

    task automatic send_instr(int t, logic [31:0] instr, vector_t op1, vector_t op2,
        lane_mask_t mask, vector_t store);
        int waited;
        waited = 0;
        while (up_credits == 0 && !aborted)
        begin
            next_cycle();
            waited++;
            if (waited > 200)
            begin
                $display("Timeout waiting for an upstream credit in test %s", test_name);
                errors++;
                aborted = 1'b1;
            end
        end
        if (!aborted)
        begin
            in_valid = 1'b1;
            in_instr = instr;
            in_thread = thread_idx_t'(t);
            exp_thread.push_back(t);
            exp_op1.push_back(op1);
            exp_op2.push_back(op2);
            exp_mask.push_back(mask);
            exp_store.push_back(store);
            next_cycle();
            in_valid = 1'b0;
        end
    endtask

    // Killed instructions are the newest ones of that thread
    task automatic do_rollback(int t, int kills);
        int i;
        int removed;
        i = exp_thread.size() - 1;
        removed = 0;
        rollback_en = 1'b1;
        rollback_thread = thread_idx_t'(t);
        while (i >= 0 && removed < kills)
        begin
            if (exp_thread[i] == t)
            begin
                exp_thread.delete(i);
                exp_op1.delete(i);
                exp_op2.delete(i);
                exp_mask.delete(i);
                exp_store.delete(i);
                removed++;
            end
            i--;
        end
        next_cycle();
        rollback_en = 1'b0;
    endtask

    // Each pop during the hold frees a queue entry, and pops stop with the execute credits
    task automatic set_hold(int on);
        if (on != 0)
        begin
            held_outputs = 0;
            held_pulses = 0;
            hold_credits = 1'b1;
        end
        else
        begin
            if (held_outputs > EXEC_CREDITS)
            begin
                $display("%0d outputs appeared while credits were held", held_outputs);
                errors++;
            end
            if (held_pulses != EXEC_CREDITS)
            begin
                $display("in_credit pulsed %0d times while credits were held", held_pulses);
                errors++;
            end
            hold_credits = 1'b0;
        end
    endtask

    initial
    begin
        int fd, t, r, isv, n;
        logic [31:0] instr;
        logic [127:0] op1, op2, store, value;
        logic [3:0] mask;
        string line;
        reset = 1'b1;
        {in_valid, wb_en, wb_is_vector, rollback_en, exec_credit_return} = '0;
        in_instr = '0;
        {in_thread, wb_thread, rollback_thread} = '0;
        wb_reg = '0;
        wb_value = '0;
        wb_mask = '0;
        lfsr_state = 16'd6;
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
        fd = $fopen("tests/operand_fetch_trace.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the trace file");
            errors++;
            aborted = 1'b1;
        end
        while (!aborted && $fgets(line, fd) > 0)
        begin
            if (line[0] == "T")
            begin
                close_test();
                void'($sscanf(line, "T %s", test_name));
                test_open = 1'b1;
            end
            else if (line[0] == "W")
            begin
                void'($sscanf(line, "W %d %h %d %h %h", t, r, isv, mask, value));
                {wb_en, wb_thread, wb_reg} = {1'b1, thread_idx_t'(t), register_idx_t'(r)};
                {wb_is_vector, wb_mask, wb_value} = {isv[0], mask, value};
                next_cycle();
                wb_en = 1'b0;
            end
            else if (line[0] == "I")
            begin
                void'($sscanf(line, "I %d %h %h %h", t, instr, op1, op2));
                void'($fgets(line, fd));
                void'($sscanf(line, "E %h %h", mask, store));
                send_instr(t, instr, op1, op2, mask, store);
            end
            else if (line[0] == "R")
            begin
                void'($sscanf(line, "R %d %d", t, n));
                do_rollback(t, n);
            end
            else if (line[0] == "P")
            begin
                void'($sscanf(line, "P %d", n));
                repeat (n) next_cycle();
            end
            else if (line[0] == "H")
            begin
                void'($sscanf(line, "H %d", n));
                set_hold(n);
            end
        end
        close_test();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !aborted)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end
endmodule

//--- operand_fetch.f
source/core_config_pkg.sv
source/core_types_pkg.sv
source/sram_2r1w.sv
source/instruction_queue.sv
source/credit_counter.sv
source/issue_control.sv
source/operand_fetch_stage.sv
source/operand_fetch_unit.sv
tests/operand_fetch_asserts.sv
tests/operand_fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module operand_fetch_tb \
    -f operand_fetch.f -o operand_fetch_sim || { echo "Build failed"; exit 1; }
./obj_dir/operand_fetch_sim > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; } \
    || echo "No failure found in log"
grep -q "TEST RESULT: PASS" sim.log || { echo "Simulation did not finish"; exit 1; }

//--- tests/operand_fetch_trace.txt
# T name | W thread reg is_vector mask value | I thread instr op1 op2, then E mask store
# R thread kills | P cycles | H 1 holds execute credits, H 0 releases them
T scalar_rw
W 0 01 0 1 00000000000000000000000011111111
W 0 02 0 1 00000000000000000000000022222222
W 1 01 0 1 000000000000000000000000aaaa0005
W 1 02 0 1 000000000000000000000000bbbb000c
I 0 00220000 11111111111111111111111111111111 22222222222222222222222222222222
E f 00000000000000000000000022222222
I 1 00220000 aaaa0005aaaa0005aaaa0005aaaa0005 bbbb000cbbbb000cbbbb000cbbbb000c
E f 000000000000000000000000bbbb000c
T vector_merge
W 0 03 1 f 33333333333333323333333133333330
W 0 03 1 5 44444443444444424444444144444440
W 0 04 1 f 55555553555555525555555155555550
I 0 a4221900 33333333444444423333333144444440 55555553555555525555555155555550
E f 55555553555555525555555155555550
T immediate_form
# Read port 2 is idle here, so the store value keeps the last scalar 2 read
I 0 5020fff0 11111111111111111111111111111111 fffffff0fffffff0fffffff0fffffff0
E f 00000000000000000000000022222222
I 1 48201234 aaaa0005aaaa0005aaaa0005aaaa0005 00001234000012340000123400001234
E 5 00000000000000000000000022222222
T mask_store
I 1 10220000 aaaa0005aaaa0005aaaa0005aaaa0005 bbbb000cbbbb000cbbbb000cbbbb000c
E c 000000000000000000000000bbbb000c
I 0 0c221900 11111111111111111111111111111111 22222222222222222222222222222222
E 1 55555553555555525555555155555550
T rollback
P 12
I 0 00220000 11111111111111111111111111111111 22222222222222222222222222222222
E f 00000000000000000000000022222222
I 1 00220000 aaaa0005aaaa0005aaaa0005aaaa0005 bbbb000cbbbb000cbbbb000cbbbb000c
E f 000000000000000000000000bbbb000c
R 0 1
P 12
I 0 00220000 11111111111111111111111111111111 22222222222222222222222222222222
E f 00000000000000000000000022222222
I 0 10220000 11111111111111111111111111111111 22222222222222222222222222222222
E 2 00000000000000000000000022222222
R 0 2
P 12
I 0 00220000 11111111111111111111111111111111 22222222222222222222222222222222
E f 00000000000000000000000022222222
I 1 00220000 aaaa0005aaaa0005aaaa0005aaaa0005 bbbb000cbbbb000cbbbb000cbbbb000c
E f 000000000000000000000000bbbb000c
I 0 08220000 11111111111111111111111111111111 22222222222222222222222222222222
E 1 00000000000000000000000022222222
I 1 10220000 aaaa0005aaaa0005aaaa0005aaaa0005 bbbb000cbbbb000cbbbb000cbbbb000c
E c 000000000000000000000000bbbb000c
T backpressure
P 12
H 1
I 0 00220000 11111111111111111111111111111111 22222222222222222222222222222222
E f 00000000000000000000000022222222
I 1 00220000 aaaa0005aaaa0005aaaa0005aaaa0005 bbbb000cbbbb000cbbbb000cbbbb000c
E f 000000000000000000000000bbbb000c
I 0 08220000 11111111111111111111111111111111 22222222222222222222222222222222
E 1 00000000000000000000000022222222
I 1 10220000 aaaa0005aaaa0005aaaa0005aaaa0005 bbbb000cbbbb000cbbbb000cbbbb000c
E c 000000000000000000000000bbbb000c
I 0 10220000 11111111111111111111111111111111 22222222222222222222222222222222
E 2 00000000000000000000000022222222
I 1 08220000 aaaa0005aaaa0005aaaa0005aaaa0005 bbbb000cbbbb000cbbbb000cbbbb000c
E 5 000000000000000000000000bbbb000c
I 0 0c221900 11111111111111111111111111111111 22222222222222222222222222222222
E 1 55555553555555525555555155555550
I 1 00220000 aaaa0005aaaa0005aaaa0005aaaa0005 bbbb000cbbbb000cbbbb000cbbbb000c
E f 000000000000000000000000bbbb000c
P 10
H 0
